// ==== logic/fifo_params.svh ====
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ----------------------------------------
// fifo geometry
// ----------------------------------------
`define FIFO_ADDR_WIDTH 4                          // 16 entries
`define FIFO_DEPTH (1 << `FIFO_ADDR_WIDTH)        // words in the array
`define FIFO_DATA_WIDTH 32                         // word width

// ----------------------------------------
// read path and thresholds
// ----------------------------------------
`define FIFO_RD_PIPE 2                             // rd_clk cycles from accept to data

// prog_empty sets at or below this word count
`define FIFO_PROG_EMPTY_ASSERT 4
// and clears once the count is above this one
`define FIFO_PROG_EMPTY_NEGATE 4

`endif

// ==== logic/fifo_pkg.sv ====
`include "fifo_params.svh"

package fifo_pkg;

    // ----------------------------------------
    // width types
    // ----------------------------------------

    // pointer with wrap bit on top
    // also used for counts and thresholds, so a full fifo fits
    typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

    // array index, pointer without wrap bit
    typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

    // payload word
    typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;

endpackage

// ==== logic/gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync
    import fifo_pkg::*;
(
    input  logic      clk,       // destination clock
    input  logic      rst_n,     // destination reset
    input  fifo_ptr_t ptr_gray,  // launched from the other domain
    output fifo_ptr_t ptr_bin    // binary pointer, 2 cycles late
);

    fifo_ptr_t sync_q1;  // first stage, may go metastable
    fifo_ptr_t sync_q2;  // settled copy

    // ----------------------------------------
    // two flop synchronizer
    // ----------------------------------------
    // only one bit moves per step in gray code,
    // so a late bit just gives the old or the new pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= ptr_gray;
            sync_q2 <= sync_q1;
        end
    end

    // ----------------------------------------
    // gray back to binary
    // ----------------------------------------
    always_comb begin
        // bit i = xor of gray bits i and up
        for (int i = 0; i < $bits(fifo_ptr_t); i++) begin
            ptr_bin[i] = ^(sync_q2 >> i);  // shifted-in zeros drop out of the xor
        end
    end

endmodule

// ==== logic/fifo_write_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_write_ctrl
    import fifo_pkg::*;
(
    input  logic       wr_clk,
    input  logic       wr_rst_n,
    input  logic       wr_en,                 // write strobe from the source
    input  fifo_ptr_t  prog_full_assert_cfg,  // prog_full sets at or above
    input  fifo_ptr_t  prog_full_negate_cfg,  // prog_full clears below
    input  fifo_ptr_t  rd_ptr_sync,           // read pointer seen in wr_clk
    output logic       mem_wr,                // accepted write
    output fifo_addr_t mem_wr_addr,
    output fifo_ptr_t  wr_ptr_gray,           // to the read side synchronizer
    output logic       full,
    output logic       prog_full,
    output logic       ovf_int                // one cycle per refused write
);

    fifo_ptr_t wr_ptr;    // binary write pointer, msb is the wrap bit
    fifo_ptr_t wr_count;  // occupancy as seen from wr_clk

    // ----------------------------------------
    // write pointer
    // ----------------------------------------
    assign mem_wr      = wr_en && !full;      // no write into a full array
    assign mem_wr_addr = fifo_addr_t'(wr_ptr); // drop the wrap bit

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_ptr <= '0;
        end else if (mem_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // registered gray copy, no glitches cross the boundary
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_ptr_gray <= '0;
        end else begin
            wr_ptr_gray <= wr_ptr ^ (wr_ptr >> 1);
        end
    end

    // ----------------------------------------
    // flags
    // ----------------------------------------
    // stale read pointer only overstates the count, safe side
    assign wr_count = wr_ptr - rd_ptr_sync;

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            full      <= 1'b0;
            prog_full <= 1'b0;
            ovf_int   <= 1'b0;
        end else begin
            // early warning: last free slot being written now
            full <= (wr_count == fifo_ptr_t'(`FIFO_DEPTH))
                 || ((wr_count == fifo_ptr_t'(`FIFO_DEPTH - 1)) && wr_en);
            if (wr_count >= prog_full_assert_cfg) begin
                prog_full <= 1'b1;
            end else if (wr_count < prog_full_negate_cfg) begin
                prog_full <= 1'b0;
            end
            ovf_int <= wr_en && full;  // write dropped this edge
        end
    end

endmodule

// ==== logic/fifo_mem.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_mem
    import fifo_pkg::*;
(
    input  logic       wr_clk,
    input  logic       rd_clk,
    input  logic       rd_rst_n,     // clears the valid line only
    input  logic       mem_wr,       // accepted write
    input  logic       mem_rd,       // accepted read
    input  fifo_addr_t mem_wr_addr,
    input  fifo_addr_t mem_rd_addr,
    input  fifo_data_t wr_data,
    output fifo_data_t rd_data,
    output logic       rd_data_val
);

    fifo_data_t mem [`FIFO_DEPTH];          // storage
    fifo_data_t rd_pipe [`FIFO_RD_PIPE];    // read data stages
    logic [`FIFO_RD_PIPE-1:0] val_pipe;     // one valid bit per stage

    // ----------------------------------------
    // write port, wr_clk
    // ----------------------------------------
    always_ff @(posedge wr_clk) begin
        if (mem_wr) begin
            mem[mem_wr_addr] <= wr_data;
        end
    end

    // ----------------------------------------
    // read port, rd_clk
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (mem_rd) begin
            rd_pipe[0] <= mem[mem_rd_addr];  // slot is stable, pointer already synced
        end
        for (int i = 1; i < `FIFO_RD_PIPE; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            val_pipe <= '0;
        end else begin
            val_pipe[0] <= mem_rd;
            for (int i = 1; i < `FIFO_RD_PIPE; i++) begin
                val_pipe[i] <= val_pipe[i-1];
            end
        end
    end

    assign rd_data     = rd_pipe[`FIFO_RD_PIPE-1];
    assign rd_data_val = val_pipe[`FIFO_RD_PIPE-1];  // marks the word leaving now

endmodule

// ==== logic/fifo_read_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_read_ctrl
    import fifo_pkg::*;
(
    input  logic       rd_clk,
    input  logic       rd_rst_n,
    input  logic       rd_en,        // read strobe from the sink
    input  logic       rd_data_val,  // word delivered by the memory
    input  fifo_ptr_t  wr_ptr_sync,  // write pointer seen in rd_clk
    output logic       mem_rd,       // accepted read
    output fifo_addr_t mem_rd_addr,
    output fifo_ptr_t  rd_ptr_gray,  // to the write side synchronizer
    output logic       empty,
    output logic       prog_empty,
    output logic       udf_int,      // one cycle per refused read
    output fifo_ptr_t  data_count    // words written minus words delivered
);

    fifo_ptr_t rd_ptr;    // binary read pointer, msb is the wrap bit
    fifo_ptr_t rd_count;  // occupancy as seen from rd_clk
    fifo_ptr_t dlv_ptr;   // counts words out of the read pipe

    // ----------------------------------------
    // read pointer
    // ----------------------------------------
    assign mem_rd      = rd_en && !empty;      // no read from an empty array
    assign mem_rd_addr = fifo_addr_t'(rd_ptr);

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_ptr <= '0;
        end else if (mem_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_ptr_gray <= '0;
        end else begin
            rd_ptr_gray <= rd_ptr ^ (rd_ptr >> 1);  // bin to gray
        end
    end

    // ----------------------------------------
    // flags
    // ----------------------------------------
    // stale write pointer only understates the count
    assign rd_count = wr_ptr_sync - rd_ptr;

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            empty      <= 1'b1;
            prog_empty <= 1'b1;
            udf_int    <= 1'b0;
        end else begin
            // early warning: last word being taken now
            empty <= (rd_count == '0) || ((rd_count == fifo_ptr_t'(1)) && rd_en);
            if (rd_count <= fifo_ptr_t'(`FIFO_PROG_EMPTY_ASSERT)) begin
                prog_empty <= 1'b1;
            end else if (rd_count > fifo_ptr_t'(`FIFO_PROG_EMPTY_NEGATE)) begin
                prog_empty <= 1'b0;
            end
            udf_int <= rd_en && empty;  // read dropped this edge
        end
    end

    // ----------------------------------------
    // data count
    // ----------------------------------------
    // words in the read pipe still count as held
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            dlv_ptr <= '0;
        end else if (rd_data_val) begin
            dlv_ptr <= dlv_ptr + 1'b1;
        end
    end

    assign data_count = wr_ptr_sync - dlv_ptr;  // wraps cleanly, 5 bit modulo

endmodule

// ==== logic/async_fifo_top.sv ====
`timescale 1ns/1ps

module async_fifo_top
    import fifo_pkg::*;
(
    // write domain
    input  logic       wr_clk,
    input  logic       wr_rst_n,
    input  logic       wr_en,
    input  fifo_data_t wr_data,
    input  fifo_ptr_t  prog_full_assert_cfg,
    input  fifo_ptr_t  prog_full_negate_cfg,
    output logic       full,
    output logic       prog_full,
    output logic       ovf_int,
    // read domain
    input  logic       rd_clk,
    input  logic       rd_rst_n,
    input  logic       rd_en,
    output fifo_data_t rd_data,
    output logic       rd_data_val,
    output logic       empty,
    output logic       prog_empty,
    output logic       udf_int,
    output fifo_ptr_t  data_count
);

    logic       mem_wr;       // accepted write, wr_clk
    logic       mem_rd;       // accepted read, rd_clk
    fifo_addr_t mem_wr_addr;
    fifo_addr_t mem_rd_addr;
    fifo_ptr_t  wr_ptr_gray;  // wr_clk, crosses to rd_clk
    fifo_ptr_t  rd_ptr_gray;  // rd_clk, crosses to wr_clk
    fifo_ptr_t  wr_ptr_sync;
    fifo_ptr_t  rd_ptr_sync;

    // ----------------------------------------
    // input side
    // ----------------------------------------
    fifo_write_ctrl u_write_ctrl (
        .wr_clk               ( wr_clk               ),
        .wr_rst_n             ( wr_rst_n             ),
        .wr_en                ( wr_en                ),
        .prog_full_assert_cfg ( prog_full_assert_cfg ),
        .prog_full_negate_cfg ( prog_full_negate_cfg ),
        .rd_ptr_sync          ( rd_ptr_sync          ),
        .mem_wr               ( mem_wr               ),
        .mem_wr_addr          ( mem_wr_addr          ),
        .wr_ptr_gray          ( wr_ptr_gray          ),
        .full                 ( full                 ),
        .prog_full            ( prog_full            ),
        .ovf_int              ( ovf_int              )
    );

    // ----------------------------------------
    // pointer crossings
    // ----------------------------------------
    gray_ptr_sync u_wr2rd_sync (      // write pointer into rd_clk
        .clk      ( rd_clk      ),
        .rst_n    ( rd_rst_n    ),
        .ptr_gray ( wr_ptr_gray ),
        .ptr_bin  ( wr_ptr_sync )
    );

    gray_ptr_sync u_rd2wr_sync (      // read pointer into wr_clk
        .clk      ( wr_clk      ),
        .rst_n    ( wr_rst_n    ),
        .ptr_gray ( rd_ptr_gray ),
        .ptr_bin  ( rd_ptr_sync )
    );

    fifo_mem u_mem (
        .wr_clk      ( wr_clk      ),
        .rd_clk      ( rd_clk      ),
        .rd_rst_n    ( rd_rst_n    ),
        .mem_wr      ( mem_wr      ),
        .mem_rd      ( mem_rd      ),
        .mem_wr_addr ( mem_wr_addr ),
        .mem_rd_addr ( mem_rd_addr ),
        .wr_data     ( wr_data     ),
        .rd_data     ( rd_data     ),
        .rd_data_val ( rd_data_val )
    );

    // ----------------------------------------
    // output side
    // ----------------------------------------
    fifo_read_ctrl u_read_ctrl (
        .rd_clk      ( rd_clk      ),
        .rd_rst_n    ( rd_rst_n    ),
        .rd_en       ( rd_en       ),
        .rd_data_val ( rd_data_val ),  // fed back for data_count
        .wr_ptr_sync ( wr_ptr_sync ),
        .mem_rd      ( mem_rd      ),
        .mem_rd_addr ( mem_rd_addr ),
        .rd_ptr_gray ( rd_ptr_gray ),
        .empty       ( empty       ),
        .prog_empty  ( prog_empty  ),
        .udf_int     ( udf_int     ),
        .data_count  ( data_count  )
    );

endmodule

// ==== tests/async_fifo_checker.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module async_fifo_checker
    import fifo_pkg::*;
(
    input  logic       wr_clk,
    input  logic       wr_rst_n,
    input  logic       wr_en,
    input  fifo_data_t wr_data,
    input  logic       full,
    input  logic       prog_full,
    input  logic       ovf_int,
    input  logic       rd_clk,
    input  logic       rd_rst_n,
    input  logic       rd_en,
    input  fifo_data_t rd_data,
    input  logic       rd_data_val,
    input  logic       empty,
    input  logic       prog_empty,
    input  logic       udf_int,
    input  fifo_ptr_t  data_count,
    input  logic       chk_stb,     // settle row, flags are stable now
    input  logic [3:0] exp_flags,   // full, prog_full, empty, prog_empty
    input  fifo_ptr_t  exp_count,   // settled occupancy from the table
    output int         value_errs,
    output int         other_errs,
    output int         words_in,
    output int         words_out
);

    fifo_data_t model_q[$];     // words accepted, not yet delivered
    fifo_data_t exp_word;
    logic       ovf_exp = 1'b0;  // refused write on the last wr_clk edge
    logic       udf_exp = 1'b0;  // refused read on the last rd_clk edge
    logic [1:0] val_line = '0;   // accepted reads, 2 rd_clk edges deep
    int         wr_errs = 0;
    int         rd_errs = 0;
    int         misc_errs = 0;
    int         n_written = 0;
    int         n_read = 0;

    assign value_errs = wr_errs + rd_errs;
    assign other_errs = misc_errs;
    assign words_in   = n_written;
    assign words_out  = n_read;

    task automatic compare_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, got);
            rd_errs++;
        end
    endtask

    task automatic compare_count(input string name, input fifo_ptr_t exp, input fifo_ptr_t got);
        if (got !== exp) begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, got);
            rd_errs++;
        end
    endtask

    // ----------------------------------------
    // write side, push and overflow
    // ----------------------------------------
    always @(posedge wr_clk) begin
        if (!wr_rst_n) begin
            ovf_exp = 1'b0;
        end else begin
            if (ovf_int !== ovf_exp) begin
                $display("FAIL %0t ovf_int expected %b got %b", $time, ovf_exp, ovf_int);
                wr_errs++;
            end
            ovf_exp = wr_en && full;  // dropped word, pulse due next edge
            if (wr_en && !full) begin
                model_q.push_back(wr_data);
                n_written++;
            end
        end
    end

    // ----------------------------------------
    // read side, pop, latency, underflow, flags
    // ----------------------------------------
    always @(posedge rd_clk) begin
        if (!rd_rst_n) begin
            udf_exp  = 1'b0;
            val_line = '0;
        end else begin
            compare_bit("udf_int", udf_exp, udf_int);
            compare_bit("rd_data_val", val_line[1], rd_data_val);
            if (rd_data_val === 1'b1) begin
                if (model_q.size() == 0) begin
                    $display("%0t: a word was delivered while no written word was left", $time);
                    misc_errs++;
                end else begin
                    exp_word = model_q.pop_front();  // oldest word first
                    if (rd_data !== exp_word) begin
                        $display("FAIL %0t rd_data expected %h got %h", $time, exp_word, rd_data);
                        rd_errs++;
                    end
                    n_read++;
                end
            end
            if (chk_stb) begin
                compare_bit("full", exp_flags[3], full);
                compare_bit("prog_full", exp_flags[2], prog_full);
                compare_bit("empty", exp_flags[1], empty);
                compare_bit("prog_empty", exp_flags[0], prog_empty);
                compare_count("data_count", exp_count, data_count);
                // written minus delivered, tracked here
                compare_count("data_count vs model", fifo_ptr_t'(n_written - n_read), data_count);
            end
            udf_exp  = rd_en && empty;
            val_line = {val_line[0], rd_en && !empty};
        end
    end

endmodule

// ==== tests/async_fifo_tb.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module async_fifo_tb
    import fifo_pkg::*;
();

    localparam int OP_WRITE  = 0;
    localparam int OP_READ   = 1;
    localparam int OP_SETTLE = 2;

    typedef struct packed {
        logic [1:0] op;
        logic [7:0] len;        // cycles of the clock the row drives
        fifo_ptr_t  pf_assert;
        fifo_ptr_t  pf_negate;
        logic [3:0] flags;      // full, prog_full, empty, prog_empty
        fifo_ptr_t  count;      // settled occupancy
    } row_t;

    row_t       rows [32];
    int         num_rows = 0;
    int         cycles = 0;     // rd_clk cycles since start
    int         limit;
    logic [31:0] rnd;           // xorshift state

    logic       wr_clk;
    logic       rd_clk;
    logic       wr_rst_n;
    logic       rd_rst_n;
    logic       wr_en;
    fifo_data_t wr_data;
    fifo_ptr_t  pf_assert_cfg;
    fifo_ptr_t  pf_negate_cfg;
    logic       rd_en;
    logic       full;
    logic       prog_full;
    logic       ovf_int;
    fifo_data_t rd_data;
    logic       rd_data_val;
    logic       empty;
    logic       prog_empty;
    logic       udf_int;
    fifo_ptr_t  data_count;
    logic       chk_stb;
    logic [3:0] exp_flags;
    fifo_ptr_t  exp_count;
    int         value_errs;
    int         other_errs;
    int         words_in;
    int         words_out;

    always #10 rd_clk = ~rd_clk;  // 20 ns
    always #14 wr_clk = ~wr_clk;  // 28 ns, slower side

    async_fifo_top i_async_fifo_top (
        .wr_clk(wr_clk), .wr_rst_n(wr_rst_n), .wr_en(wr_en), .wr_data(wr_data),
        .prog_full_assert_cfg(pf_assert_cfg), .prog_full_negate_cfg(pf_negate_cfg),
        .full(full), .prog_full(prog_full), .ovf_int(ovf_int),
        .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .rd_en(rd_en),
        .rd_data(rd_data), .rd_data_val(rd_data_val), .empty(empty),
        .prog_empty(prog_empty), .udf_int(udf_int), .data_count(data_count)
    );

    async_fifo_checker i_async_fifo_checker (
        .wr_clk(wr_clk), .wr_rst_n(wr_rst_n), .wr_en(wr_en), .wr_data(wr_data),
        .full(full), .prog_full(prog_full), .ovf_int(ovf_int),
        .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .rd_en(rd_en), .rd_data(rd_data),
        .rd_data_val(rd_data_val), .empty(empty), .prog_empty(prog_empty),
        .udf_int(udf_int), .data_count(data_count), .chk_stb(chk_stb),
        .exp_flags(exp_flags), .exp_count(exp_count), .value_errs(value_errs),
        .other_errs(other_errs), .words_in(words_in), .words_out(words_out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input int op, input int len, input int pfa, input int pfn,
                           input logic [3:0] flags, input int count);
        row_t r;
        r.op        = op[1:0];
        r.len       = len[7:0];
        r.pf_assert = fifo_ptr_t'(pfa);
        r.pf_negate = fifo_ptr_t'(pfn);
        r.flags     = flags;
        r.count     = fifo_ptr_t'(count);
        rows[num_rows] = r;
        num_rows++;
    endtask

    // ----------------------------------------
    // row actions
    // ----------------------------------------
    task automatic write_burst(input int n);
        for (int i = 0; i < n; i++) begin
            rnd = xorshift32(rnd);
            wr_en   <= 1'b1;
            wr_data <= rnd;
            @(posedge wr_clk);
        end
        wr_en <= 1'b0;
    endtask

    task automatic read_burst(input int n);
        @(posedge rd_clk);
        for (int i = 0; i < n; i++) begin
            rd_en <= 1'b1;  // back to back, refused once empty
            @(posedge rd_clk);
        end
        rd_en <= 1'b0;
    endtask

    task automatic settle_check(input row_t r);
        repeat (r.len) @(posedge wr_clk);  // both strobes idle
        @(posedge rd_clk);
        exp_flags <= r.flags;
        exp_count <= r.count;
        chk_stb   <= 1'b1;
        @(posedge rd_clk);
        chk_stb <= 1'b0;
    endtask

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    task automatic build_table();
        add_row(OP_SETTLE, 8, 12, 10, 4'b0011, 0);   // out of reset
        add_row(OP_WRITE, 4, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0001, 4);   // 4 held, prog_empty high
        add_row(OP_WRITE, 1, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0000, 5);   // 5 held, prog_empty low
        add_row(OP_WRITE, 6, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0000, 11);  // below assert, prog_full low
        add_row(OP_READ, 14, 12, 10, 4'b0000, 0);    // last 3 underflow
        add_row(OP_SETTLE, 8, 12, 10, 4'b0011, 0);
        add_row(OP_WRITE, 20, 12, 10, 4'b0000, 0);   // 16 taken, 4 overflow
        add_row(OP_SETTLE, 8, 12, 10, 4'b1100, 16);
        add_row(OP_READ, 5, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0100, 11);  // hysteresis keeps prog_full
        add_row(OP_READ, 2, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0000, 9);   // under negate, cleared
        add_row(OP_READ, 5, 12, 10, 4'b0000, 0);
        add_row(OP_SETTLE, 8, 12, 10, 4'b0001, 4);
        add_row(OP_READ, 6, 12, 10, 4'b0000, 0);     // 2 underflow
        add_row(OP_SETTLE, 8, 12, 10, 4'b0011, 0);
    endtask

    initial begin
        rd_clk        = 1'b0;
        wr_clk        = 1'b0;
        wr_rst_n      = 1'b0;
        rd_rst_n      = 1'b0;
        wr_en         = 1'b0;
        wr_data       = '0;
        rd_en         = 1'b0;
        pf_assert_cfg = fifo_ptr_t'(12);
        pf_negate_cfg = fifo_ptr_t'(10);
        chk_stb       = 1'b0;
        exp_flags     = '0;
        exp_count     = '0;
        rnd           = 32'hfc8f_ec78;
        build_table();
        limit = 100 + 8 * num_rows;
        for (int r = 0; r < num_rows; r++) begin
            limit += 2 * rows[r].len;
        end
        repeat (10) @(posedge rd_clk);
        wr_rst_n <= 1'b1;
        rd_rst_n <= 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge wr_clk);
            pf_assert_cfg <= rows[r].pf_assert;
            pf_negate_cfg <= rows[r].pf_negate;
            case (rows[r].op)
                OP_WRITE: write_burst(rows[r].len);
                OP_READ:  read_burst(rows[r].len);
                default:  settle_check(rows[r]);
            endcase
        end
        repeat (4) @(posedge rd_clk);
        $display("words written %0d, delivered %0d, value errors %0d, other errors %0d",
                 words_in, words_out, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run length bound, counted in rd_clk
    always @(posedge rd_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run was still going after %0d rd_clk cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/fifo_pkg.sv
logic/gray_ptr_sync.sv
logic/fifo_write_ctrl.sv
logic/fifo_mem.sv
logic/fifo_read_ctrl.sv
logic/async_fifo_top.sv
tests/async_fifo_checker.sv
tests/async_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: async_fifo

sources:
  - include_dirs:
      - logic
    files:
      - logic/fifo_pkg.sv
      - logic/gray_ptr_sync.sv
      - logic/fifo_write_ctrl.sv
      - logic/fifo_mem.sv
      - logic/fifo_read_ctrl.sv
      - logic/async_fifo_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tests/async_fifo_checker.sv
      - tests/async_fifo_tb.sv
